// File: uart_sys_input.txt
// Columns: op _ address or character _ expected value or write data
// Ops: 01 write, 02 read, 03 tx frame, 04 rx frame (stop bit), 05 status bit, 06/07 random tx, 08 idle frames
02_08_00000004
02_04_00000002
01_08_00000006
02_08_00000006
01_00_000000a5
03_00_000000a5
06_00_00000000
07_00_00000000
06_00_00000000
07_00_00000000
04_3c_00000001
04_c3_00000001
05_02_00000001
02_00_0000003c
02_00_000000c3
05_02_00000000
// First byte goes straight to the shifter, four fill the FIFO, the last is dropped
01_00_00000011
01_00_00000012
01_00_00000013
01_00_00000014
01_00_00000015
01_00_00000016
03_00_00000011
05_00_00000001
03_00_00000012
03_00_00000013
03_00_00000014
03_00_00000015
08_00_00000001
05_01_00000001
// Low stop bit
04_5a_00000000
05_03_00000000
02_00_0000005a
05_03_00000001
01_04_00000008
05_03_00000000
// One frame more than the receive FIFO holds
04_01_00000001
04_02_00000001
04_03_00000001
04_04_00000001
04_05_00000001
05_04_00000001
02_00_00000001
02_00_00000002
02_00_00000003
02_00_00000004
02_00_00000000
01_04_00000010
05_04_00000000

// File: uart_sys_top.f
uart_pkg.sv
uart_baud_timer.sv
uart_fifo.sv
uart_tx_ctrl.sv
uart_rx_ctrl.sv
uart_apb_regs.sv
uart_sys_top.sv
uart_sys_tb.sv

// File: Bender.yml
package:
  name: uart_sys

sources:
  - uart_pkg.sv
  - uart_baud_timer.sv
  - uart_fifo.sv
  - uart_tx_ctrl.sv
  - uart_rx_ctrl.sv
  - uart_apb_regs.sv
  - uart_sys_top.sv
  - target: simulation
    files:
      - uart_sys_tb.sv

// File: uart_sys_tb.sv
//////////////////////////////
// Testbench for uart_sys_top driven by the operations in uart_sys_input.txt
// Acts as the serial terminal on rx_i and tx_o at the current divisor
// All inputs change on the falling clock edge
//////////////////////////////
module uart_sys_tb import uart_pkg::*; ();

  localparam int tx_depth  = 4;
  localparam int rx_depth  = 4;
  localparam int reset_div = 4;
  localparam int max_ops   = 64;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              psel = 1'b0;
  logic              penable = 1'b0;
  logic              pwrite = 1'b0;
  logic [addr_w-1:0] paddr = '0;
  logic [31:0]       pwdata = '0;
  logic [31:0]       prdata;
  logic              rx = 1'b1;
  logic              tx;

  // Each entry holds op, address or character, and expected value or write data
  logic [47:0]       ops [max_ops];
  logic [data_w-1:0] lcg_q [$];
  logic [31:0]       lcg_state = 32'hb546_8960;
  int                cur_div = reset_div;
  int                cycles = 0;
  int                cycle_limit = 32'h7fff_ffff;
  int                checks = 0;
  int                errors = 0;

  always #5 clk = ~clk;

  uart_sys_top #(
    .tx_depth  (tx_depth),
    .rx_depth  (rx_depth),
    .reset_div (reset_div)
  ) uut (
    .clk_i     (clk),
    .rst_i     (rst),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .rx_i      (rx),
    .tx_o      (tx)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [data_w-1:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_char(input string name, input logic [data_w-1:0] got,
                            input logic [data_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // Starts on a falling edge and returns on the falling edge after the access
  task automatic apb_write(input logic [addr_w-1:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [addr_w-1:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // Taken at the edge that ends the access, before the pop lands
    @(posedge clk);
    data    = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_frame(input logic [data_w-1:0] ch, input logic stop_bit);
    logic [data_w+1:0] frame;
    frame = {stop_bit, ch, 1'b0};
    for (int i = 0; i < data_w + 2; i++) begin
      rx = frame[i];
      repeat (os_rate * cur_div) @(negedge clk);
    end
    rx = 1'b1;
    // A low stop bit needs an idle bit before the next start edge
    if (!stop_bit) begin
      repeat (os_rate * cur_div) @(negedge clk);
    end
  endtask

  // Waits for the start bit and then samples every bit near its middle
  task automatic expect_frame(input logic [data_w-1:0] exp);
    logic [data_w-1:0] ch;
    logic              start_bit;
    logic              stop_bit;
    while (tx !== 1'b0) begin
      @(negedge clk);
    end
    repeat (os_rate / 2 * cur_div) @(negedge clk);
    start_bit = tx;
    for (int i = 0; i < data_w; i++) begin
      repeat (os_rate * cur_div) @(negedge clk);
      ch[i] = tx;
    end
    repeat (os_rate * cur_div) @(negedge clk);
    stop_bit = tx;
    check_flag("tx_o start bit", start_bit, 1'b0);
    check_char("tx_o character", ch, exp);
    check_flag("tx_o stop bit", stop_bit, 1'b1);
  endtask

  task automatic expect_idle(input int frames);
    logic idle;
    idle = 1'b1;
    repeat (frames * os_rate * (data_w + 2) * cur_div) begin
      @(negedge clk);
      if (tx !== 1'b1) begin
        idle = 1'b0;
      end
    end
    check_flag("tx_o idle", idle, 1'b1);
  endtask

  initial begin
    int          n_ops;
    int          frames;
    int          max_div;
    int          errs_before;
    logic [7:0]  op;
    logic [7:0]  arg;
    logic [31:0] val;
    logic [31:0] rd;
    for (int i = 0; i < max_ops; i++) begin
      ops[i] = '0;
    end
    $readmemh("uart_sys_input.txt", ops);
    n_ops   = 0;
    frames  = 0;
    max_div = reset_div;
    while ((n_ops < max_ops) && (ops[n_ops][47:40] != 8'h00)) begin
      op  = ops[n_ops][47:40];
      val = ops[n_ops][31:0];
      if ((op == 8'h03) || (op == 8'h04) || (op == 8'h07)) begin
        frames++;
      end else if (op == 8'h08) begin
        frames += int'(val);
      end else if ((op == 8'h01) && (ops[n_ops][39:32] == reg_div) && (int'(val) > max_div)) begin
        max_div = int'(val);
      end
      n_ops++;
    end
    cycle_limit = frames * 170 * max_div + 2000;
    if (n_ops == 0) begin
      errors++;
      $display("The data file uart_sys_input.txt holds no operations");
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_flag("tx_o after reset", tx, 1'b1);

    for (int i = 0; i < n_ops; i++) begin
      op          = ops[i][47:40];
      arg         = ops[i][39:32];
      val         = ops[i][31:0];
      errs_before = errors;
      case (op)
        8'h01: begin
          apb_write(arg[addr_w-1:0], val);
          if (arg[addr_w-1:0] == reg_div) begin
            cur_div = int'(val[div_w-1:0]);
          end
        end
        8'h02: begin
          apb_read(arg[addr_w-1:0], rd);
          check_word($sformatf("prdata at 0x%0h", arg), rd, val);
        end
        8'h03: expect_frame(val[data_w-1:0]);
        8'h04: send_frame(arg, val[0]);
        8'h05: begin
          apb_read(reg_status, rd);
          check_flag($sformatf("status[%0d]", arg), rd[arg], val[0]);
        end
        8'h06: begin
          lcg_q.push_back(lcg_byte());
          apb_write(reg_data, 32'(lcg_q[$]));
        end
        8'h07: begin
          if (lcg_q.size() == 0) begin
            errors++;
            $display("No random character is left to compare with a frame on tx_o");
          end else begin
            expect_frame(lcg_q.pop_front());
          end
        end
        8'h08: expect_idle(int'(val));
        default: begin
          errors++;
          $display("Unknown operation %02h on data line %0d", op, i + 1);
        end
      endcase
      $display("test %0d op %02h %s", i + 1, op, (errors == errs_before) ? "ok" : "failed");
    end

    $display("tests %0d, checks %0d, errors %0d", n_ops, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: uart_sys_top.sv
//////////////////////////////
// UART subsystem behind an APB slave, single clock domain
// Serial format is fixed 8N1 with 16x oversampling
//////////////////////////////
module uart_sys_top import uart_pkg::*; #(
  parameter int               tx_depth  = 4,
  parameter int               rx_depth  = 4,
  parameter logic [div_w-1:0] reset_div = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [addr_w-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  input  logic              rx_i,
  output logic              tx_o
);

  logic              tick;
  logic [div_w-1:0]  div;

  // Transmit path
  logic              tx_push;
  logic [data_w-1:0] tx_wdata;
  logic              tx_full;
  logic              tx_pop;
  logic [data_w-1:0] tx_head;
  logic              tx_empty;

  // Receive path
  logic              rx_push;
  rx_entry_t         rx_entry;
  logic              rx_full;
  logic              rx_pop;
  rx_entry_t         rx_head;
  logic              rx_empty;
  logic              overrun;

  uart_apb_regs #(
    .reset_div (reset_div)
  ) u_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .tx_full_i  (tx_full),
    .tx_empty_i (tx_empty),
    .rx_head_i  (rx_head),
    .rx_empty_i (rx_empty),
    .overrun_i  (overrun),
    .tx_push_o  (tx_push),
    .tx_wdata_o (tx_wdata),
    .rx_pop_o   (rx_pop),
    .div_o      (div)
  );

  uart_baud_timer u_baud (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .div_i  (div),
    .tick_o (tick)
  );

  uart_fifo #(
    .entry_t (logic [data_w-1:0]),
    .depth   (tx_depth)
  ) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (tx_push),
    .wdata_i (tx_wdata),
    .full_o  (tx_full),
    .pop_i   (tx_pop),
    .rdata_o (tx_head),
    .empty_o (tx_empty)
  );

  uart_tx_ctrl u_tx (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (tick),
    .empty_i (tx_empty),
    .data_i  (tx_head),
    .pop_o   (tx_pop),
    .tx_o    (tx_o)
  );

  uart_rx_ctrl u_rx (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .tick_i    (tick),
    .rx_i      (rx_i),
    .full_i    (rx_full),
    .push_o    (rx_push),
    .entry_o   (rx_entry),
    .overrun_o (overrun)
  );

  uart_fifo #(
    .entry_t (rx_entry_t),
    .depth   (rx_depth)
  ) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rx_push),
    .wdata_i (rx_entry),
    .full_o  (rx_full),
    .pop_i   (rx_pop),
    .rdata_o (rx_head),
    .empty_o (rx_empty)
  );

endmodule

// File: uart_apb_regs.sv
//////////////////////////////
// APB slave for DATA, STATUS and DIVISOR, no wait states
// Reads of DATA pop the receive FIFO, empty reads return zero
//////////////////////////////
module uart_apb_regs import uart_pkg::*; #(
  parameter logic [div_w-1:0] reset_div = 4
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [addr_w-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  input  logic              tx_full_i,
  input  logic              tx_empty_i,
  input  rx_entry_t         rx_head_i,
  input  logic              rx_empty_i,
  input  logic              overrun_i,
  output logic              tx_push_o,
  output logic [data_w-1:0] tx_wdata_o,
  output logic              rx_pop_o,
  output logic [div_w-1:0]  div_o
);

  logic        wr_acc;
  logic        rd_acc;
  logic        status_wr;
  logic        frame_err_q;
  logic        overrun_q;
  logic [31:0] status_word;

  // Access phase only, setup cycles have no effect
  assign wr_acc    = psel_i && penable_i && pwrite_i;
  assign rd_acc    = psel_i && penable_i && !pwrite_i;
  assign status_wr = wr_acc && (paddr_i == reg_status);

  assign tx_push_o  = wr_acc && (paddr_i == reg_data) && !tx_full_i;
  assign tx_wdata_o = pwdata_i[data_w-1:0];
  assign rx_pop_o   = rd_acc && (paddr_i == reg_data) && !rx_empty_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      div_o       <= reset_div;
      frame_err_q <= 1'b0;
      overrun_q   <= 1'b0;
    end else begin
      if (wr_acc && (paddr_i == reg_div)) begin
        div_o <= pwdata_i[div_w-1:0];
      end
      // A new event wins over a clear in the same cycle
      if (rx_pop_o && rx_head_i.frame_err) begin
        frame_err_q <= 1'b1;
      end else if (status_wr && pwdata_i[st_frame_err]) begin
        frame_err_q <= 1'b0;
      end
      if (overrun_i) begin
        overrun_q <= 1'b1;
      end else if (status_wr && pwdata_i[st_overrun]) begin
        overrun_q <= 1'b0;
      end
    end
  end

  always_comb begin
    status_word               = '0;
    status_word[st_tx_full]   = tx_full_i;
    status_word[st_tx_empty]  = tx_empty_i;
    status_word[st_rx_valid]  = !rx_empty_i;
    status_word[st_frame_err] = frame_err_q;
    status_word[st_overrun]   = overrun_q;
  end

  always_comb begin
    case (paddr_i)
      reg_data:   prdata_o = rx_empty_i ? '0 : 32'(rx_head_i.data);
      reg_status: prdata_o = status_word;
      reg_div:    prdata_o = 32'(div_o);
      default:    prdata_o = '0;
    endcase
  end

endmodule

// File: uart_rx_ctrl.sv
//////////////////////////////
// 8N1 receiver with mid-bit sampling on baud ticks
// Entry is pushed one cycle after the stop sample, lost if FIFO full
//////////////////////////////
module uart_rx_ctrl import uart_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      tick_i,
  input  logic      rx_i,
  input  logic      full_i,
  output logic      push_o,
  output rx_entry_t entry_o,
  output logic      overrun_o
);

  localparam int cnt_w = $clog2(os_rate);
  localparam int idx_w = $clog2(data_w);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t            state_q;
  logic              rx_meta_q;
  logic              rx_sync_q;
  logic              rx_prev_q;
  logic [cnt_w-1:0]  tick_cnt_q;
  logic [idx_w-1:0]  bit_idx_q;
  logic [data_w-1:0] shift_q;
  logic              done_q;
  logic              mid_start;
  logic              bit_end;

  assign mid_start = tick_i && (tick_cnt_q == cnt_w'(os_rate / 2 - 1));
  assign bit_end   = tick_i && (tick_cnt_q == cnt_w'(os_rate - 1));

  assign push_o    = done_q && !full_i;
  assign overrun_o = done_q && full_i;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      case (state_q)
        st_idle: begin
          if (rx_prev_q && !rx_sync_q) begin
            state_q    <= st_start;
            tick_cnt_q <= '0;
          end
        end
        st_start: begin
          // Half a bit later the start bit must still be low
          if (mid_start) begin
            state_q    <= rx_sync_q ? st_idle : st_data;
            tick_cnt_q <= '0;
            bit_idx_q  <= '0;
          end
        end
        st_data: begin
          if (bit_end) begin
            tick_cnt_q <= '0;
            if (bit_idx_q == idx_w'(data_w - 1)) begin
              state_q <= st_stop;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= st_idle;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == st_data) && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[data_w-1:1]};
    end
    if ((state_q == st_stop) && bit_end) begin
      entry_o.data      <= shift_q;
      entry_o.frame_err <= !rx_sync_q;
    end
  end

endmodule

// File: uart_tx_ctrl.sv
//////////////////////////////
// 8N1 transmitter fed from the transmit FIFO
// Start bit begins on the clock after the pop, not aligned to a tick
//////////////////////////////
module uart_tx_ctrl import uart_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              tick_i,
  input  logic              empty_i,
  input  logic [data_w-1:0] data_i,
  output logic              pop_o,
  output logic              tx_o
);

  localparam int cnt_w = $clog2(os_rate);
  localparam int idx_w = $clog2(data_w);

  typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

  state_t            state_q;
  logic [cnt_w-1:0]  tick_cnt_q;
  logic [idx_w-1:0]  bit_idx_q;
  logic [data_w-1:0] shift_q;
  logic              bit_end;

  // Take the next character whenever the line is idle
  assign pop_o   = (state_q == st_idle) && !empty_i;
  assign bit_end = tick_i && (tick_cnt_q == cnt_w'(os_rate - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      tx_o       <= 1'b1;
      tick_cnt_q <= '0;
      bit_idx_q  <= '0;
    end else begin
      if (tick_i) begin
        tick_cnt_q <= tick_cnt_q + 1'b1;
      end
      case (state_q)
        st_idle: begin
          if (pop_o) begin
            state_q    <= st_start;
            tx_o       <= 1'b0;
            tick_cnt_q <= '0;
          end
        end
        st_start: begin
          if (bit_end) begin
            state_q    <= st_data;
            tx_o       <= shift_q[0];
            bit_idx_q  <= '0;
            tick_cnt_q <= '0;
          end
        end
        st_data: begin
          if (bit_end) begin
            tick_cnt_q <= '0;
            if (bit_idx_q == idx_w'(data_w - 1)) begin
              state_q <= st_stop;
              tx_o    <= 1'b1;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
              // Next bit, matches the shift below
              tx_o      <= shift_q[1];
            end
          end
        end
        default: begin
          if (bit_end) begin
            state_q    <= st_idle;
            tick_cnt_q <= '0;
          end
        end
      endcase
    end
  end

  // Character shifts out LSB first
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shift_q <= data_i;
    end else if ((state_q == st_data) && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

// File: uart_fifo.sv
//////////////////////////////
// Synchronous FIFO, entry type set by parameter
// Push while full is dropped even if a pop happens in the same cycle
//////////////////////////////
module uart_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  depth   = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   push_i,
  input  entry_t wdata_i,
  output logic   full_o,
  input  logic   pop_i,
  output entry_t rdata_o,
  output logic   empty_o
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);

  entry_t           mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);
  assign rdata_o = mem[rd_ptr_q];
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

// File: uart_baud_timer.sv
//////////////////////////////
// Oversample tick generator, one tick every div_i cycles
// A divisor of 0 or 1 gives a tick on every cycle
//////////////////////////////
module uart_baud_timer import uart_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [div_w-1:0] div_i,
  output logic             tick_o
);

  logic [div_w-1:0] cnt_q;
  logic [div_w-1:0] reload;

  // Divisor is only sampled at the wrap
  assign reload = (div_i > 1) ? div_i - 1'b1 : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= reload;
      tick_o <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_o <= 1'b0;
    end
  end

endmodule

// File: uart_pkg.sv
//////////////////////////////
// Shared UART constants, register map and receive entry type
// Register offsets are byte addresses on a 4-bit APB address
//////////////////////////////
package uart_pkg;

  // Character and divisor widths
  localparam int data_w  = 8;
  localparam int div_w   = 16;

  // Baud ticks per serial bit
  localparam int os_rate = 16;

  localparam int addr_w  = 4;

  // Register offsets
  localparam logic [addr_w-1:0] reg_data   = 4'h0;
  localparam logic [addr_w-1:0] reg_status = 4'h4;
  localparam logic [addr_w-1:0] reg_div    = 4'h8;

  // STATUS bit positions, frame error and overrun are sticky
  localparam int st_tx_full   = 0;
  localparam int st_tx_empty  = 1;
  localparam int st_rx_valid  = 2;
  localparam int st_frame_err = 3;
  localparam int st_overrun   = 4;

  // One received character with its stop-bit check result
  typedef struct packed {
    logic              frame_err;
    logic [data_w-1:0] data;
  } rx_entry_t;

endpackage
